// ==== Bender.yml ====
package:
  name: memory_bus_guard

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_guard_pkg.sv
      - rtl/mem_cmd_if.sv
      - rtl/mem_req_arbiter.sv
      - rtl/mem_cmd_fifo.sv
      - rtl/mem_access_seq.sv
      - rtl/memory_bus_guard.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/memory_bus_guard_tb.sv

// ==== bench/mem_model.sv ====
`timescale 1ns/10ps

module mem_model
(
	input logic clk,
	input logic reset,
	input logic req,
	input mem_guard_pkg::addr_t addr,
	input mem_guard_pkg::data_t wdata,
	input mem_guard_pkg::mem_acc_type_t acc_type,
	output logic busy,
	output mem_guard_pkg::data_t rdata
);

	localparam int NUM_WORDS = 64;

	mem_guard_pkg::data_t words [NUM_WORDS];
	mem_guard_pkg::addr_t acc_addr;
	mem_guard_pkg::data_t acc_wdata;
	mem_guard_pkg::mem_acc_type_t acc_kind;
	integer remaining;
	integer seed = 16;

	// busy rises the cycle after req and stays high 1 to 4 cycles
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_WORDS; i++)
				words[i] <= 1000 + i;
			busy <= 1'b0;
			remaining <= 0;
			rdata <= '0;
		end
		else if (req && !busy)
		begin
			busy <= 1'b1;
			remaining <= $random(seed) & 3;
			acc_addr <= addr;
			acc_wdata <= wdata;
			acc_kind <= acc_type;
		end
		else if (busy)
		begin
			if (remaining == 0)
			begin
				busy <= 1'b0;
				// read data shows up together with the fall of busy
				if (acc_kind == mem_guard_pkg::MEM_ACC_WRITE)
					words[acc_addr[8:3]] <= acc_wdata;
				else
					rdata <= words[acc_addr[8:3]];
			end
			else
				remaining <= remaining - 1;
		end
	end

endmodule

// ==== bench/memory_bus_guard_tb.sv ====
`timescale 1ns/10ps

module memory_bus_guard_tb;

	localparam int NUM_TESTS = 6;
	localparam int WORST_TEST_CYCLES = 300;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * WORST_TEST_CYCLES + 200;

	logic clk;
	logic reset;
	logic req_read_instr;
	mem_guard_pkg::addr_t addr_read_instr;
	logic busy_read_instr;
	mem_guard_pkg::data_t rdata_read_instr;
	logic req_read_data;
	mem_guard_pkg::addr_t addr_read_data;
	logic busy_read_data;
	mem_guard_pkg::data_t rdata_read_data;
	logic req_write_data;
	mem_guard_pkg::addr_t addr_write_data;
	mem_guard_pkg::data_t wdata_write_data;
	logic busy_write_data;
	logic can_accept_cmd;
	logic status_busy;
	logic mem_req;
	mem_guard_pkg::addr_t mem_addr;
	mem_guard_pkg::data_t mem_wdata;
	mem_guard_pkg::mem_acc_type_t mem_acc_type;
	logic mem_busy;
	mem_guard_pkg::data_t mem_rdata;

	int cycle_count;
	int error_count;
	int tests_passed;
	int tests_failed;
	int mem_req_count;

	memory_bus_guard u_memory_bus_guard (.*);

	mem_model u_mem_model
	(
		.clk(clk),
		.reset(reset),
		.req(mem_req),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.acc_type(mem_acc_type),
		.busy(mem_busy),
		.rdata(mem_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory accesses actually issued, sampled where mem_req is stable
	always @(negedge clk)
	begin
		if (mem_req)
			mem_req_count++;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// initial memory contents
	function automatic mem_guard_pkg::data_t preload_word(input mem_guard_pkg::addr_t a);
		return 1000 + a[8:3];
	endfunction

	task automatic compare_data(input mem_guard_pkg::data_t got, input mem_guard_pkg::data_t exp,
		input string what);
		if (got !== exp)
		begin
			error_count++;
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			error_count++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// one-cycle pulses, called on a falling edge
	task automatic pulse_requests(input logic instr, input logic rd, input logic wr,
		input mem_guard_pkg::addr_t ia, input mem_guard_pkg::addr_t ra,
		input mem_guard_pkg::addr_t wa, input mem_guard_pkg::data_t wd);
		req_read_instr = instr;
		req_read_data = rd;
		req_write_data = wr;
		addr_read_instr = ia;
		addr_read_data = ra;
		addr_write_data = wa;
		wdata_write_data = wd;
		@(negedge clk);
		req_read_instr = 1'b0;
		req_read_data = 1'b0;
		req_write_data = 1'b0;
	endtask

	task automatic wait_all_idle(output int cycles);
		cycles = 0;
		while (busy_read_instr || busy_read_data || busy_write_data)
		begin
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			tests_passed++;
			$display("test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic test_reset_state();
		int errs;
		errs = error_count;
		compare_bit(busy_read_instr, 1'b0, "busy_read_instr after reset");
		compare_bit(busy_read_data, 1'b0, "busy_read_data after reset");
		compare_bit(busy_write_data, 1'b0, "busy_write_data after reset");
		compare_bit(can_accept_cmd, 1'b1, "can_accept_cmd after reset");
		compare_bit(status_busy, 1'b0, "status_busy after reset");
		compare_bit(mem_req, 1'b0, "mem_req after reset");
		finish_test("reset_state", errs);
	endtask

	task automatic test_instr_read();
		int errs;
		int cycles;
		errs = error_count;
		pulse_requests(1'b1, 1'b0, 1'b0, 32'h40, '0, '0, '0);
		wait_all_idle(cycles);
		compare_bit(cycles >= 5, 1'b1, "instruction read took five cycles or more");
		compare_data(rdata_read_instr, preload_word(32'h40), "rdata_read_instr");
		finish_test("instr_read", errs);
	endtask

	task automatic test_write_then_read();
		int errs;
		int cycles;
		errs = error_count;
		pulse_requests(1'b0, 1'b0, 1'b1, '0, '0, 32'h88, 64'hdead_beef_0123_4567);
		wait_all_idle(cycles);
		compare_bit(cycles >= 5, 1'b1, "data write took five cycles or more");
		pulse_requests(1'b0, 1'b1, 1'b0, '0, 32'h88, '0, '0);
		wait_all_idle(cycles);
		compare_data(rdata_read_data, 64'hdead_beef_0123_4567, "rdata_read_data after write");
		finish_test("write_then_read", errs);
	endtask

	task automatic test_simultaneous();
		int errs;
		int cycles;
		errs = error_count;
		// write wins the first slot, so the read sees the new word
		pulse_requests(1'b1, 1'b1, 1'b1, 32'h18, 32'h100, 32'h100, 64'h0bad_cafe_5555_aaaa);
		wait_all_idle(cycles);
		compare_data(rdata_read_data, 64'h0bad_cafe_5555_aaaa, "rdata_read_data");
		compare_data(rdata_read_instr, preload_word(32'h18), "rdata_read_instr");
		finish_test("simultaneous", errs);
	endtask

	task automatic test_request_while_busy();
		int errs;
		int cycles;
		int reqs_before;
		errs = error_count;
		reqs_before = mem_req_count;
		pulse_requests(1'b0, 1'b1, 1'b0, '0, 32'h20, '0, '0);
		compare_bit(busy_read_data, 1'b1, "busy_read_data before second pulse");
		pulse_requests(1'b0, 1'b1, 1'b0, '0, 32'h28, '0, '0);
		wait_all_idle(cycles);
		repeat (10) @(negedge clk);
		compare_bit(busy_read_data, 1'b0, "busy_read_data after settling");
		compare_bit(mem_req_count - reqs_before == 1, 1'b1, "exactly one memory access");
		compare_data(rdata_read_data, preload_word(32'h20), "rdata_read_data");
		finish_test("request_while_busy", errs);
	endtask

	task automatic test_status_outputs();
		int errs;
		logic any_busy;
		errs = error_count;
		pulse_requests(1'b1, 1'b0, 1'b1, 32'h30, '0, 32'h1f8, 64'h1234);
		any_busy = busy_read_instr || busy_read_data || busy_write_data;
		compare_bit(any_busy, 1'b1, "requesters busy after pulses");
		while (any_busy)
		begin
			compare_bit(status_busy, 1'b1, "status_busy while outstanding");
			compare_bit(can_accept_cmd, 1'b0, "can_accept_cmd while outstanding");
			@(negedge clk);
			any_busy = busy_read_instr || busy_read_data || busy_write_data;
		end
		compare_bit(status_busy, 1'b0, "status_busy when idle");
		compare_bit(can_accept_cmd, 1'b1, "can_accept_cmd when idle");
		finish_test("status_outputs", errs);
	endtask

	initial
	begin
		reset = 1'b1;
		req_read_instr = 1'b0;
		req_read_data = 1'b0;
		req_write_data = 1'b0;
		addr_read_instr = '0;
		addr_read_data = '0;
		addr_write_data = '0;
		wdata_write_data = '0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		mem_req_count = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_instr_read();
		test_write_then_read();
		test_simultaneous();
		test_request_while_busy();
		test_status_outputs();
		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== rtl/mem_access_seq.sv ====
`timescale 1ns/10ps

module mem_access_seq
(
	input logic clk,
	input logic reset,
	mem_cmd_if.consumer q,
	output logic mem_req,
	output mem_guard_pkg::addr_t mem_addr,
	output mem_guard_pkg::data_t mem_wdata,
	output mem_guard_pkg::mem_acc_type_t mem_acc_type,
	input logic mem_busy,
	input mem_guard_pkg::data_t mem_rdata,
	output logic done,
	output mem_guard_pkg::req_source_t done_source,
	output mem_guard_pkg::data_t done_data
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT_BUSY_RISE,
		ST_WAIT_BUSY_FALL
	} seq_state_t;

	seq_state_t state;
	mem_guard_pkg::mem_cmd_t cur_cmd;

	assign q.pop = (state == ST_IDLE) && !q.empty;

	always_ff @(posedge clk)
	begin
		if (q.pop)
			cur_cmd <= q.pop_cmd;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (!q.empty)
						state <= ST_ISSUE;
				ST_ISSUE:
					state <= ST_WAIT_BUSY_RISE;
				// memory raises busy the cycle after req
				ST_WAIT_BUSY_RISE:
					if (mem_busy)
						state <= ST_WAIT_BUSY_FALL;
				ST_WAIT_BUSY_FALL:
					if (!mem_busy)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assign mem_req = (state == ST_ISSUE);
	assign mem_addr = cur_cmd.addr;
	assign mem_wdata = cur_cmd.data;
	assign mem_acc_type = cur_cmd.acc_type;

	// read data is only valid in the cycle busy drops
	assign done = (state == ST_WAIT_BUSY_FALL) && !mem_busy;
	assign done_source = cur_cmd.source;
	assign done_data = mem_rdata;

endmodule

// ==== rtl/mem_cmd_fifo.sv ====
`timescale 1ns/10ps

`include "mem_guard_config.svh"

module mem_cmd_fifo
#(
	parameter type PAYLOAD_T = mem_guard_pkg::mem_cmd_t,
	parameter int DEPTH = `MEM_GUARD_FIFO_DEPTH
)
(
	input logic clk,
	input logic reset,
	mem_cmd_if.buffer q
);

	localparam int PTR_W = $clog2(DEPTH);

	PAYLOAD_T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign q.full = (count == DEPTH[PTR_W:0]);
	assign q.empty = (count == '0);

	// requests that would overflow or underflow are dropped
	assign do_push = q.push && !q.full;
	assign do_pop = q.pop && !q.empty;

	assign q.pop_cmd = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= q.push_cmd;
	end

	// pointers wrap naturally since DEPTH is a power of two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== rtl/mem_cmd_if.sv ====
`timescale 1ns/10ps

`include "mem_guard_config.svh"

interface mem_cmd_if;

	logic push;
	mem_guard_pkg::mem_cmd_t push_cmd;
	logic full;

	logic pop;
	mem_guard_pkg::mem_cmd_t pop_cmd;
	logic empty;

	// arbiter side
	modport producer
	(
		output push, push_cmd,
		input full
	);

	modport buffer
	(
		input push, push_cmd, pop,
		output full, pop_cmd, empty
	);

	// sequencer side
	modport consumer
	(
		output pop,
		input pop_cmd, empty
	);

endinterface

// ==== rtl/mem_guard_config.svh ====
`ifndef MEM_GUARD_CONFIG_SVH
`define MEM_GUARD_CONFIG_SVH

// memory access port widths
`define MEM_GUARD_ADDR_WIDTH 32
`define MEM_GUARD_DATA_WIDTH 64

// command queue entries, power of two
`define MEM_GUARD_FIFO_DEPTH 4

`endif

// ==== rtl/mem_guard_pkg.sv ====
`include "mem_guard_config.svh"

package mem_guard_pkg;

	typedef enum logic
	{
		MEM_ACC_READ,
		MEM_ACC_WRITE
	} mem_acc_type_t;

	// also used as the index of the per-requester state
	typedef enum logic [1:0]
	{
		SRC_INSTR,
		SRC_DATA_RD,
		SRC_DATA_WR
	} req_source_t;

	typedef logic [`MEM_GUARD_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`MEM_GUARD_DATA_WIDTH-1:0] data_t;

	typedef struct packed
	{
		req_source_t source;
		mem_acc_type_t acc_type;
		addr_t addr;
		data_t data;
	} mem_cmd_t;

endpackage

// ==== rtl/mem_req_arbiter.sv ====
`timescale 1ns/10ps

module mem_req_arbiter
(
	input logic clk,
	input logic reset,
	input logic req_read_instr,
	input logic req_read_data,
	input logic req_write_data,
	input mem_guard_pkg::addr_t addr_read_instr,
	input mem_guard_pkg::addr_t addr_read_data,
	input mem_guard_pkg::addr_t addr_write_data,
	input mem_guard_pkg::data_t wdata_write_data,
	input logic done,
	input mem_guard_pkg::req_source_t done_source,
	input mem_guard_pkg::data_t done_data,
	output logic busy_read_instr,
	output logic busy_read_data,
	output logic busy_write_data,
	output mem_guard_pkg::data_t rdata_read_instr,
	output mem_guard_pkg::data_t rdata_read_data,
	output logic can_accept_cmd,
	output logic status_busy,
	mem_cmd_if.producer cmd
);

	localparam int NUM_SRC = 3;

	logic [NUM_SRC-1:0] req_vec;
	logic [NUM_SRC-1:0] accept;
	logic [NUM_SRC-1:0] busy;
	logic [NUM_SRC-1:0] pend_valid;
	mem_guard_pkg::mem_cmd_t pend_cmd [NUM_SRC];
	mem_guard_pkg::mem_cmd_t new_cmd [NUM_SRC];
	mem_guard_pkg::req_source_t sel_source;

	assign req_vec = {req_write_data, req_read_data, req_read_instr};

	// a pulse from a requester that is still busy is dropped
	assign accept = req_vec & ~busy;

	assign new_cmd[mem_guard_pkg::SRC_INSTR] = '{source: mem_guard_pkg::SRC_INSTR,
		acc_type: mem_guard_pkg::MEM_ACC_READ, addr: addr_read_instr, data: '0};
	assign new_cmd[mem_guard_pkg::SRC_DATA_RD] = '{source: mem_guard_pkg::SRC_DATA_RD,
		acc_type: mem_guard_pkg::MEM_ACC_READ, addr: addr_read_data, data: '0};
	assign new_cmd[mem_guard_pkg::SRC_DATA_WR] = '{source: mem_guard_pkg::SRC_DATA_WR,
		acc_type: mem_guard_pkg::MEM_ACC_WRITE, addr: addr_write_data,
		data: wdata_write_data};

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_SRC; i++)
		begin
			if (accept[i])
				pend_cmd[i] <= new_cmd[i];
		end
	end

	// fixed priority: write, then data read, then instruction
	always_comb
	begin
		if (pend_valid[mem_guard_pkg::SRC_DATA_WR])
			sel_source = mem_guard_pkg::SRC_DATA_WR;
		else if (pend_valid[mem_guard_pkg::SRC_DATA_RD])
			sel_source = mem_guard_pkg::SRC_DATA_RD;
		else
			sel_source = mem_guard_pkg::SRC_INSTR;
	end

	assign cmd.push = (|pend_valid) && !cmd.full;
	assign cmd.push_cmd = pend_cmd[sel_source];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pend_valid <= '0;
			busy <= '0;
		end
		else
		begin
			pend_valid <= pend_valid | accept;
			busy <= busy | accept;
			if (cmd.push)
				pend_valid[sel_source] <= 1'b0;
			if (done)
				busy[done_source] <= 1'b0;
		end
	end

	// read results load with the completion and hold until the next one
	always_ff @(posedge clk)
	begin
		if (done && done_source == mem_guard_pkg::SRC_INSTR)
			rdata_read_instr <= done_data;
		if (done && done_source == mem_guard_pkg::SRC_DATA_RD)
			rdata_read_data <= done_data;
	end

	assign busy_read_instr = busy[mem_guard_pkg::SRC_INSTR];
	assign busy_read_data = busy[mem_guard_pkg::SRC_DATA_RD];
	assign busy_write_data = busy[mem_guard_pkg::SRC_DATA_WR];

	assign status_busy = |busy;
	assign can_accept_cmd = ~(|busy);

endmodule

// ==== rtl/memory_bus_guard.sv ====
`timescale 1ns/10ps

module memory_bus_guard
(
	input logic clk,
	input logic reset,

	input logic req_read_instr,
	input mem_guard_pkg::addr_t addr_read_instr,
	output logic busy_read_instr,
	output mem_guard_pkg::data_t rdata_read_instr,

	input logic req_read_data,
	input mem_guard_pkg::addr_t addr_read_data,
	output logic busy_read_data,
	output mem_guard_pkg::data_t rdata_read_data,

	input logic req_write_data,
	input mem_guard_pkg::addr_t addr_write_data,
	input mem_guard_pkg::data_t wdata_write_data,
	output logic busy_write_data,

	output logic can_accept_cmd,
	output logic status_busy,

	output logic mem_req,
	output mem_guard_pkg::addr_t mem_addr,
	output mem_guard_pkg::data_t mem_wdata,
	output mem_guard_pkg::mem_acc_type_t mem_acc_type,
	input logic mem_busy,
	input mem_guard_pkg::data_t mem_rdata
);

	logic done;
	mem_guard_pkg::req_source_t done_source;
	mem_guard_pkg::data_t done_data;

	mem_cmd_if cmd_q ();

	mem_req_arbiter u_arbiter
	(
		.clk(clk),
		.reset(reset),
		.req_read_instr(req_read_instr),
		.req_read_data(req_read_data),
		.req_write_data(req_write_data),
		.addr_read_instr(addr_read_instr),
		.addr_read_data(addr_read_data),
		.addr_write_data(addr_write_data),
		.wdata_write_data(wdata_write_data),
		.done(done),
		.done_source(done_source),
		.done_data(done_data),
		.busy_read_instr(busy_read_instr),
		.busy_read_data(busy_read_data),
		.busy_write_data(busy_write_data),
		.rdata_read_instr(rdata_read_instr),
		.rdata_read_data(rdata_read_data),
		.can_accept_cmd(can_accept_cmd),
		.status_busy(status_busy),
		.cmd(cmd_q.producer)
	);

	mem_cmd_fifo
	#(
		.PAYLOAD_T(mem_guard_pkg::mem_cmd_t)
	) u_fifo
	(
		.clk(clk),
		.reset(reset),
		.q(cmd_q.buffer)
	);

	mem_access_seq u_seq
	(
		.clk(clk),
		.reset(reset),
		.q(cmd_q.consumer),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_acc_type(mem_acc_type),
		.mem_busy(mem_busy),
		.mem_rdata(mem_rdata),
		.done(done),
		.done_source(done_source),
		.done_data(done_data)
	);

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/mem_guard_pkg.sv
rtl/mem_cmd_if.sv
rtl/mem_req_arbiter.sv
rtl/mem_cmd_fifo.sv
rtl/mem_access_seq.sv
rtl/memory_bus_guard.sv
bench/mem_model.sv
bench/memory_bus_guard_tb.sv
